// File: sim.f
+incdir+verilog
verilog/pid_pkg.sv
verilog/cfg_if.sv
verilog/cfg_decoder.sv
verilog/instr_dispatch.sv
verilog/oversample_filter.sv
verilog/pid_filter.sv
verilog/output_filter.sv
verilog/pid_pipeline.sv
tests/tb_pid_pipeline.sv

// File: tests/tb_pid_pipeline.sv
`timescale 1ns/10ps
`include "pid_macros.svh"

module tb_pid_pipeline;
    import pid_pkg::*;

    typedef struct packed {
        logic [31:0]            due;     // Cycle the item must show up
        logic [`PID_W_CHAN-1:0] chan;
        logic [31:0]            data;
    } exp_t;

    logic                          clk_in = 1'b0;
    logic                          reset;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    logic [`PID_W_ADR-1:0]         wb_adr;
    logic [`PID_W_WB-1:0]          wb_wdata;
    logic [`PID_W_WB-1:0]          wb_rdata;
    logic                          wb_ack;
    logic                          src_dv;
    logic [`PID_W_SRC-1:0]         src_sel;
    logic signed [`PID_W_DIN-1:0]  src_data;
    logic                          ovr_dv;
    logic [`PID_W_CHAN-1:0]        ovr_chan;
    logic signed [`PID_W_DIN-1:0]  ovr_data;
    logic                          out_dv;
    logic [`PID_W_CHAN-1:0]        out_chan;
    logic signed [`PID_W_DOUT-1:0] out_data;

    int          cycle  = 0;
    int          errors = 0;
    int          checks = 0;
    logic [15:0] lfsr   = 16'd43;
    exp_t        ovr_q [$];    // Expected averaged samples
    exp_t        out_q [$];    // Expected controller outputs

    // ------------------------------
    // Reference model state
    // ------------------------------
    bit     map_en [`PID_N_SRC];
    int     map_ch [`PID_N_SRC];
    int     os_exp;
    longint os_sum [`PID_N_CHAN];
    int     os_cnt [`PID_N_CHAN];
    longint sp     [`PID_N_CHAN];
    longint kp     [`PID_N_CHAN];
    longint ki     [`PID_N_CHAN];
    longint kd     [`PID_N_CHAN];
    longint e1     [`PID_N_CHAN];    // Zero until the first error
    longint e2     [`PID_N_CHAN];
    longint mult   [`PID_N_CHAN];
    int     shift  [`PID_N_CHAN];
    longint lo     [`PID_N_CHAN];
    longint hi     [`PID_N_CHAN];
    longint acc    [`PID_N_CHAN];

    pid_pipeline pid_pipeline_inst (.*);

    always #4 clk_in = ~clk_in;    // 8 ns period

    always @(posedge clk_in) cycle <= cycle + 1;

    // x^16 + x^14 + x^13 + x^11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERROR %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cycle);
        end
    endtask

    task automatic check_event(input string name, input exp_t item,
                               input logic [`PID_W_CHAN-1:0] chan, input logic [31:0] data);
        checks++;
        assert (item.due == cycle) else begin
            errors++;
            $display("%s_dv came at cycle %0d, expected at cycle %0d", name, cycle, item.due);
        end
        compare({name, "_chan"}, 32'(chan), 32'(item.chan));
        compare({name, "_data"}, data, item.data);
    endtask

    task automatic model_config(input cfg_reg_e op, input logic [3:0] idx, input logic [31:0] d);
        case (op)
            REG_SRC_MAP: begin
                map_en[idx[2:0]] = d[2];
                map_ch[idx[2:0]] = d[1:0];
            end
            REG_OS: begin
                os_exp = d[2:0];
                for (int c = 0; c < `PID_N_CHAN; c++) begin
                    os_sum[c] = 0;    // Partial averages dropped
                    os_cnt[c] = 0;
                end
            end
            REG_SETPOINT: sp[idx[1:0]]    = $signed(d[17:0]);
            REG_KP:       kp[idx[1:0]]    = $signed(d[15:0]);
            REG_KI:       ki[idx[1:0]]    = $signed(d[15:0]);
            REG_KD:       kd[idx[1:0]]    = $signed(d[15:0]);
            REG_MULT:     mult[idx[1:0]]  = $signed(d[15:0]);
            REG_RSHIFT:   shift[idx[1:0]] = d[5:0];
            REG_MIN:      lo[idx[1:0]]    = $signed(d);
            REG_MAX:      hi[idx[1:0]]    = $signed(d);
            default:      ;
        endcase
    endtask

    // One source sample through all four stages
    task automatic model_sample(input logic [2:0] sel, input logic signed [17:0] x);
        int     ch;
        longint avg;
        longint e;
        longint d;
        longint v;
        exp_t   item;
        if (map_en[sel]) begin
            ch = map_ch[sel];
            os_sum[ch] += x;
            os_cnt[ch]++;
            if (os_cnt[ch] == (1 << os_exp)) begin
                avg        = os_sum[ch] >>> os_exp;    // Floor of the mean
                os_sum[ch] = 0;
                os_cnt[ch] = 0;
                item.due   = cycle + 2;
                item.chan  = ch[1:0];
                item.data  = 32'(avg) & 32'h3ffff;
                ovr_q.push_back(item);
                e      = sp[ch] - avg;
                d      = kp[ch] * (e - e1[ch]) + ki[ch] * e + kd[ch] * (e - 2 * e1[ch] + e2[ch]);
                e2[ch] = e1[ch];
                e1[ch] = e;
                v      = acc[ch] + ((d * mult[ch]) >>> shift[ch]);
                if (v < lo[ch]) begin
                    v = lo[ch];
                end else if (v > hi[ch]) begin
                    v = hi[ch];
                end
                acc[ch]   = v;
                item.due  = cycle + 6;
                item.data = 32'(v);
                out_q.push_back(item);
            end
        end
    endtask

    always @(posedge clk_in) begin
        if (!reset && src_dv) begin
            model_sample(src_sel, src_data);
        end
    end

    // ------------------------------
    // Output checkers
    // ------------------------------
    always @(posedge clk_in) begin : ovr_check
        exp_t item;
        if (!reset && ovr_dv) begin
            assert (ovr_q.size() != 0) else begin
                errors++;
                $display("ovr_dv fired at cycle %0d with no average expected", cycle);
            end
            if (ovr_q.size() != 0) begin
                item = ovr_q.pop_front();
                check_event("ovr", item, ovr_chan, {14'b0, ovr_data});
            end
        end else if (!reset && ovr_q.size() != 0 && ovr_q[0].due < cycle) begin
            item = ovr_q.pop_front();
            errors++;
            $display("No ovr_dv for channel %0d due at cycle %0d", item.chan, item.due);
        end
    end

    always @(posedge clk_in) begin : out_check
        exp_t item;
        if (!reset && out_dv) begin
            assert (out_q.size() != 0) else begin
                errors++;
                $display("out_dv fired at cycle %0d with no output expected", cycle);
            end
            if (out_q.size() != 0) begin
                item = out_q.pop_front();
                check_event("out", item, out_chan, out_data);
            end
        end else if (!reset && out_q.size() != 0 && out_q[0].due < cycle) begin
            item = out_q.pop_front();
            errors++;
            $display("No out_dv for channel %0d due at cycle %0d", item.chan, item.due);
        end
    end

    // ------------------------------
    // Stimulus tasks
    // ------------------------------
    task automatic bus_access(input logic we, input cfg_reg_e op, input logic [3:0] idx,
                              input logic [31:0] wdata);
        int waited;
        @(posedge clk_in);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= {op, idx};
        wb_wdata <= wdata;
        waited = 0;
        do begin
            @(posedge clk_in);
            waited++;
        end while (!wb_ack && waited < 16);
        if (!wb_ack) begin
            abort_run("No wb_ack within 16 cycles of a bus request");
        end else begin
            checks++;
            assert (waited == 2) else begin
                errors++;
                $display("wb_ack came %0d cycles after the request, not 1", waited - 1);
            end
            if (!we) begin
                compare("wb_rdata", wb_rdata, 32'h0);    // Write-only space
            end
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            @(posedge clk_in);
            checks++;
            assert (!wb_ack) else begin
                errors++;
                $display("wb_ack raised twice for one request");
            end
            if (we) begin
                model_config(op, idx, wdata);
            end
        end
    endtask

    task automatic drive_sample(input logic [2:0] sel, input logic signed [17:0] x);
        @(posedge clk_in);
        src_dv   <= 1'b1;
        src_sel  <= sel;
        src_data <= x;
    endtask

    task automatic idle_cycle();
        @(posedge clk_in);
        src_dv <= 1'b0;
    endtask

    // Until every expected item has been seen
    task automatic drain();
        int waited;
        waited = 0;
        do begin
            @(posedge clk_in);
            waited++;
        end while ((ovr_q.size() != 0 || out_q.size() != 0) && waited < 64);
        if (ovr_q.size() != 0 || out_q.size() != 0) begin
            abort_run("Expected pipeline outputs still pending after 64 cycles");
        end
    endtask

    initial begin
        int i;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_wdata = '0;
        src_dv   = 1'b0;
        src_sel  = '0;
        src_data = '0;
        repeat (8) @(posedge clk_in);
        reset <= 1'b0;

        // Unmapped sources, reads return zero
        bus_access(1'b0, REG_KP, 4'h0, 32'h0);
        bus_access(1'b0, REG_MAX, 4'h3, 32'h0);
        for (i = 0; i < 8; i++) begin
            drive_sample(3'(i), 18'(i * 1111));
        end
        idle_cycle();
        drain();

        // ------------------------------
        // Dispatch with os = 0
        // ------------------------------
        bus_access(1'b1, REG_SRC_MAP, 4'h0, 32'h6);    // src0 to ch2
        bus_access(1'b1, REG_SRC_MAP, 4'h1, 32'h4);    // src1 to ch0
        bus_access(1'b1, REG_SRC_MAP, 4'h2, 32'h5);    // src2 to ch1
        bus_access(1'b1, REG_SRC_MAP, 4'h5, 32'h5);    // src5 to ch1
        drive_sample(3'd0, 18'sd100);
        drive_sample(3'd1, -18'sd200);
        drive_sample(3'd2, 18'sd300);
        drive_sample(3'd5, 18'sd400);
        drive_sample(3'd0, -18'sd500);
        idle_cycle();
        drain();
        bus_access(1'b1, REG_SRC_MAP, 4'h5, 32'h0);    // src5 disabled
        drive_sample(3'd5, 18'sd77);
        drive_sample(3'd2, 18'sd78);
        drive_sample(3'd5, 18'sd79);
        idle_cycle();
        drain();

        // Oversample by 4, random sources and gaps
        bus_access(1'b1, REG_OS, 4'h0, 32'h2);
        for (i = 0; i < 96; i++) begin
            if (rand_bits(2) == 0) begin
                idle_cycle();
            end else begin
                drive_sample(3'(rand_bits(3)), 18'(rand_bits(18)));
            end
        end
        idle_cycle();
        drain();
        bus_access(1'b1, REG_OS, 4'h0, 32'h0);

        // ------------------------------
        // PID on ch3, fresh history
        // ------------------------------
        bus_access(1'b1, REG_SETPOINT, 4'h3, 32'd1000);
        bus_access(1'b1, REG_KP, 4'h3, 32'd3);
        bus_access(1'b1, REG_KI, 4'h3, 32'd2);
        bus_access(1'b1, REG_KD, 4'h3, 32'd1);
        bus_access(1'b1, REG_MULT, 4'h3, 32'd1);
        bus_access(1'b1, REG_MIN, 4'h3, 32'h8000_0000);
        bus_access(1'b1, REG_MAX, 4'h3, 32'h7fff_ffff);
        bus_access(1'b1, REG_SRC_MAP, 4'h6, 32'h7);    // src6 to ch3
        bus_access(1'b0, REG_KP, 4'h3, 32'h0);         // Written register, still reads zero
        for (i = 0; i < 12; i++) begin
            drive_sample(3'd6, 18'(i * 110 - 40));    // Back to back on one channel
            if (i % 3 == 1) begin
                drive_sample(3'd1, 18'(i * 7));
            end
        end
        idle_cycle();
        drain();

        // Scaled and clamped, then error sign flips
        bus_access(1'b1, REG_SETPOINT, 4'h3, 32'd0);
        bus_access(1'b1, REG_KP, 4'h3, 32'd2);
        bus_access(1'b1, REG_KI, 4'h3, 32'd4);
        bus_access(1'b1, REG_MULT, 4'h3, 32'd5);
        bus_access(1'b1, REG_RSHIFT, 4'h3, 32'd2);
        bus_access(1'b1, REG_MIN, 4'h3, 32'hffff_ff38);    // -200
        bus_access(1'b1, REG_MAX, 4'h3, 32'd300);
        for (i = 0; i < 8; i++) begin
            drive_sample(3'd6, -18'sd50);
        end
        for (i = 0; i < 10; i++) begin
            drive_sample(3'd6, 18'sd80);
            if (i % 2 == 0) begin
                idle_cycle();
            end
        end
        idle_cycle();
        drain();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog/cfg_decoder.sv
`timescale 1ns/10ps
`include "pid_macros.svh"

module cfg_decoder (
    input  logic                  clk_in,
    input  logic                  reset,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [`PID_W_ADR-1:0] wb_adr,
    input  logic [`PID_W_WB-1:0]  wb_wdata,
    output logic [`PID_W_WB-1:0]  wb_rdata,
    output logic                  wb_ack,
    cfg_if.master                 cfg
);
    import pid_pkg::*;

    logic req;    // Request seen and not yet acked

    assign req      = wb_cyc && wb_stb && !wb_ack;
    assign wb_rdata = '0;    // Write-only register space

    // ------------------------------
    // Handshake
    // ------------------------------
    always_ff @(posedge clk_in) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            cfg.wr_en <= 1'b0;
        end else begin
            wb_ack    <= req;             // Cleared ack blocks a repeat
            cfg.wr_en <= req && wb_we;    // Lines up with ack
        end
    end

    // Address split into opcode and index
    always_ff @(posedge clk_in) begin
        cfg.reg_op <= cfg_reg_e'(wb_adr[7:4]);
        cfg.chan   <= wb_adr[3:0];
        cfg.data   <= wb_wdata;
    end

    a_ack_needs_req: assert property (@(posedge clk_in) disable iff (reset)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack raised without cyc and stb");

endmodule

// File: verilog/cfg_if.sv
`timescale 1ns/10ps
`include "pid_macros.svh"

interface cfg_if;
    import pid_pkg::*;

    logic                 wr_en;     // One-cycle write strobe
    cfg_reg_e             reg_op;    // Target register
    logic [3:0]           chan;      // Channel or source index
    logic [`PID_W_WB-1:0] data;

    // Decoder drives, stages latch what they own
    modport master (output wr_en, reg_op, chan, data);
    modport sink   (input wr_en, reg_op, chan, data);

endinterface

// File: verilog/instr_dispatch.sv
`timescale 1ns/10ps
`include "pid_macros.svh"

module instr_dispatch (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic                         src_dv,
    input  logic [`PID_W_SRC-1:0]        src_sel,
    input  logic signed [`PID_W_DIN-1:0] src_data,
    cfg_if.sink                          cfg,
    output pid_pkg::sample_t             sample
);
    import pid_pkg::*;

    logic                   src_en   [`PID_N_SRC];    // Source mapped
    logic [`PID_W_CHAN-1:0] src_chan [`PID_N_SRC];    // Target channel
    logic [`PID_W_SRC-1:0]  wr_src;

    assign wr_src = cfg.chan[`PID_W_SRC-1:0];

    // Source map
    always_ff @(posedge clk_in) begin
        if (reset) begin
            for (int i = 0; i < `PID_N_SRC; i++) begin
                src_en[i] <= 1'b0;
            end
        end else if (cfg.wr_en && cfg.reg_op == REG_SRC_MAP) begin
            src_en[wr_src]   <= cfg.data[2];
            src_chan[wr_src] <= cfg.data[`PID_W_CHAN-1:0];
        end
    end

    // Forward mapped samples, drop the rest
    always_ff @(posedge clk_in) begin
        if (reset) begin
            sample.dv <= 1'b0;
        end else begin
            sample.dv <= src_dv && src_en[src_sel];
        end
        sample.chan <= src_chan[src_sel];
        sample.data <= src_data;
    end

    a_chan_range: assert property (@(posedge clk_in) disable iff (reset)
        sample.dv |-> $past(src_dv) && (sample.chan < `PID_N_CHAN))
        else $error("dispatch output without source or channel out of range");

endmodule

// File: verilog/output_filter.sv
`timescale 1ns/10ps
`include "pid_macros.svh"

module output_filter (
    input  logic                          clk_in,
    input  logic                          reset,
    input  pid_pkg::delta_t               delta,
    cfg_if.sink                           cfg,
    output logic                          out_dv,
    output logic [`PID_W_CHAN-1:0]        out_chan,
    output logic signed [`PID_W_DOUT-1:0] out_data
);
    import pid_pkg::*;

    localparam int W_RS   = 6;                             // Shift up to 63
    localparam int W_PROD = `PID_W_COMP + `PID_W_COEF;    // delta * mult

    logic signed [`PID_W_COEF-1:0] mult    [`PID_N_CHAN];
    logic [W_RS-1:0]               rshift  [`PID_N_CHAN];
    logic signed [`PID_W_DOUT-1:0] out_min [`PID_N_CHAN];
    logic signed [`PID_W_DOUT-1:0] out_max [`PID_N_CHAN];
    logic signed [`PID_W_DOUT-1:0] acc     [`PID_N_CHAN];    // Running output
    logic [`PID_W_CHAN-1:0]        wr_chan;
    logic signed [W_PROD-1:0]      scaled;
    logic signed [W_PROD-1:0]      sum;
    logic signed [`PID_W_DOUT-1:0] clamped;

    logic                          s1_dv;
    logic [`PID_W_CHAN-1:0]        s1_chan;
    logic signed [W_PROD-1:0]      s1_val;
    logic signed [`PID_W_DOUT-1:0] s1_acc;

    assign wr_chan = cfg.chan[`PID_W_CHAN-1:0];
    assign scaled  = (W_PROD'(delta.data) * W_PROD'(mult[delta.chan])) >>> rshift[delta.chan];
    assign sum     = W_PROD'(s1_acc) + s1_val;

    // Saturate to the channel limits
    always_comb begin
        if (sum < W_PROD'(out_min[s1_chan])) begin
            clamped = out_min[s1_chan];
        end else if (sum > W_PROD'(out_max[s1_chan])) begin
            clamped = out_max[s1_chan];
        end else begin
            clamped = sum[`PID_W_DOUT-1:0];
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            for (int i = 0; i < `PID_N_CHAN; i++) begin
                mult[i]    <= '0;
                rshift[i]  <= '0;
                out_min[i] <= '0;
                out_max[i] <= '0;
            end
        end else if (cfg.wr_en) begin
            case (cfg.reg_op)
                REG_MULT:   mult[wr_chan]    <= cfg.data[`PID_W_COEF-1:0];
                REG_RSHIFT: rshift[wr_chan]  <= cfg.data[W_RS-1:0];
                REG_MIN:    out_min[wr_chan] <= cfg.data[`PID_W_DOUT-1:0];
                REG_MAX:    out_max[wr_chan] <= cfg.data[`PID_W_DOUT-1:0];
                default:    ;
            endcase
        end
    end

    // ------------------------------
    // Stage 1: scale, fetch output
    // ------------------------------
    always_ff @(posedge clk_in) begin
        if (reset) begin
            s1_dv <= 1'b0;
        end else begin
            s1_dv <= delta.dv;
        end
        s1_chan <= delta.chan;
        s1_val  <= scaled;
        // Same channel in stage 2 takes the value being stored
        s1_acc  <= (s1_dv && s1_chan == delta.chan) ? clamped : acc[delta.chan];
    end

    // ------------------------------
    // Stage 2: accumulate and present
    // ------------------------------
    always_ff @(posedge clk_in) begin
        if (reset) begin
            out_dv <= 1'b0;
            for (int i = 0; i < `PID_N_CHAN; i++) begin
                acc[i] <= '0;
            end
        end else begin
            out_dv <= s1_dv;
            if (s1_dv) begin
                acc[s1_chan] <= clamped;
            end
        end
        out_chan <= s1_chan;
        out_data <= clamped;
    end

    a_out_limits: assert property (@(posedge clk_in) disable iff (reset)
        out_dv && $past(out_min[s1_chan] <= out_max[s1_chan]) |->
            out_data >= $past(out_min[s1_chan]) && out_data <= $past(out_max[s1_chan]))
        else $error("out_data outside channel limits");

endmodule

// File: verilog/oversample_filter.sv
`timescale 1ns/10ps
`include "pid_macros.svh"

module oversample_filter (
    input  logic             clk_in,
    input  logic             reset,
    input  pid_pkg::sample_t sample_in,
    cfg_if.sink              cfg,
    output pid_pkg::sample_t sample_out
);
    import pid_pkg::*;

    localparam int W_CNT = (1 << `PID_W_OS) - 1;    // Counts to 2^os - 1
    localparam int W_SUM = `PID_W_DIN + W_CNT;      // Room for 2^os samples

    logic [`PID_W_OS-1:0]    os;                    // Global exponent
    logic signed [W_SUM-1:0] sums [`PID_N_CHAN];
    logic [W_CNT-1:0]        cnts [`PID_N_CHAN];
    logic signed [W_SUM-1:0] sum_next;
    logic signed [W_SUM-1:0] avg;
    logic                    done;                  // Completing sample
    logic                    os_wr;

    assign os_wr    = cfg.wr_en && cfg.reg_op == REG_OS;
    assign sum_next = sums[sample_in.chan] + W_SUM'(sample_in.data);
    assign avg      = sum_next >>> os;              // Floor of the mean
    assign done     = cnts[sample_in.chan] == W_CNT'((1 << os) - 1);

    // Per-channel accumulation
    always_ff @(posedge clk_in) begin
        if (reset || os_wr) begin
            for (int i = 0; i < `PID_N_CHAN; i++) begin
                sums[i] <= '0;
                cnts[i] <= '0;
            end
        end else if (sample_in.dv) begin
            sums[sample_in.chan] <= done ? '0 : sum_next;
            cnts[sample_in.chan] <= done ? '0 : cnts[sample_in.chan] + 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            os            <= '0;
            sample_out.dv <= 1'b0;
        end else begin
            if (os_wr) begin
                os <= cfg.data[`PID_W_OS-1:0];
            end
            sample_out.dv <= sample_in.dv && done && !os_wr;    // Lost to the clear
        end
        sample_out.chan <= sample_in.chan;
        sample_out.data <= avg[`PID_W_DIN-1:0];
    end

endmodule

// File: verilog/pid_filter.sv
`timescale 1ns/10ps
`include "pid_macros.svh"

module pid_filter (
    input  logic             clk_in,
    input  logic             reset,
    input  pid_pkg::sample_t sample_in,
    cfg_if.sink              cfg,
    output pid_pkg::delta_t  delta
);
    import pid_pkg::*;

    localparam int W_ERR  = `PID_W_DIN + 1;    // setpoint - x
    localparam int W_DIF  = `PID_W_DIN + 3;    // e - 2e1 + e2
    localparam int W_COMP = `PID_W_COMP;

    logic signed [`PID_W_DIN-1:0]  setpoint [`PID_N_CHAN];
    logic signed [`PID_W_COEF-1:0] kp       [`PID_N_CHAN];
    logic signed [`PID_W_COEF-1:0] ki       [`PID_N_CHAN];
    logic signed [`PID_W_COEF-1:0] kd       [`PID_N_CHAN];
    logic signed [W_ERR-1:0]       e1       [`PID_N_CHAN];    // Last error
    logic signed [W_ERR-1:0]       e2       [`PID_N_CHAN];    // One before
    pid_state_e                    hist     [`PID_N_CHAN];
    logic [`PID_W_CHAN-1:0]        wr_chan;
    logic signed [W_ERR-1:0]       e;
    logic signed [W_ERR-1:0]       e1_eff;
    logic signed [W_ERR-1:0]       e2_eff;

    logic                   p1_dv;
    logic [`PID_W_CHAN-1:0] p1_chan;
    logic signed [W_DIF-1:0] p1_dp;    // Proportional difference
    logic signed [W_DIF-1:0] p1_di;    // Integral term, the error itself
    logic signed [W_DIF-1:0] p1_dd;    // Second difference

    assign wr_chan = cfg.chan[`PID_W_CHAN-1:0];
    assign e       = W_ERR'(setpoint[sample_in.chan]) - W_ERR'(sample_in.data);

    // Missing history reads as zero
    assign e1_eff = (hist[sample_in.chan] != HIST_EMPTY) ? e1[sample_in.chan] : '0;
    assign e2_eff = (hist[sample_in.chan] == HIST_FULL) ? e2[sample_in.chan] : '0;

    // Coefficient registers
    always_ff @(posedge clk_in) begin
        if (reset) begin
            for (int i = 0; i < `PID_N_CHAN; i++) begin
                setpoint[i] <= '0;
                kp[i]       <= '0;
                ki[i]       <= '0;
                kd[i]       <= '0;
            end
        end else if (cfg.wr_en) begin
            case (cfg.reg_op)
                REG_SETPOINT: setpoint[wr_chan] <= cfg.data[`PID_W_DIN-1:0];
                REG_KP:       kp[wr_chan]       <= cfg.data[`PID_W_COEF-1:0];
                REG_KI:       ki[wr_chan]       <= cfg.data[`PID_W_COEF-1:0];
                REG_KD:       kd[wr_chan]       <= cfg.data[`PID_W_COEF-1:0];
                default:      ;
            endcase
        end
    end

    // ------------------------------
    // Stage 1: error terms and history
    // ------------------------------
    always_ff @(posedge clk_in) begin
        if (reset) begin
            p1_dv <= 1'b0;
            for (int i = 0; i < `PID_N_CHAN; i++) begin
                hist[i] <= HIST_EMPTY;
            end
        end else begin
            p1_dv <= sample_in.dv;
            if (sample_in.dv) begin
                hist[sample_in.chan] <= (hist[sample_in.chan] == HIST_EMPTY) ?
                                        HIST_ONE : HIST_FULL;
            end
        end
        if (sample_in.dv) begin
            e1[sample_in.chan] <= e;
            e2[sample_in.chan] <= e1_eff;
        end
        p1_chan <= sample_in.chan;
        p1_dp   <= W_DIF'(e) - W_DIF'(e1_eff);
        p1_di   <= W_DIF'(e);
        p1_dd   <= W_DIF'(e) - (W_DIF'(e1_eff) <<< 1) + W_DIF'(e2_eff);
    end

    // ------------------------------
    // Stage 2: weighted sum
    // ------------------------------
    always_ff @(posedge clk_in) begin
        if (reset) begin
            delta.dv <= 1'b0;
        end else begin
            delta.dv <= p1_dv;
        end
        delta.chan <= p1_chan;
        delta.data <= W_COMP'(kp[p1_chan]) * W_COMP'(p1_dp)
                    + W_COMP'(ki[p1_chan]) * W_COMP'(p1_di)
                    + W_COMP'(kd[p1_chan]) * W_COMP'(p1_dd);
    end

    a_stage_gap: assert property (@(posedge clk_in) disable iff (reset)
        delta.dv == $past(p1_dv))
        else $error("PID stage 2 valid out of step with stage 1");

endmodule

// File: verilog/pid_macros.svh
`ifndef PID_MACROS_SVH
`define PID_MACROS_SVH

// Channel and source counts
`define PID_N_CHAN 4
`define PID_W_CHAN 2
`define PID_N_SRC  8
`define PID_W_SRC  3

// Datapath widths
`define PID_W_DIN  18    // Signed sample
`define PID_W_COMP 48    // PID arithmetic
`define PID_W_DOUT 32    // Clamped output
`define PID_W_COEF 16    // Gains and output multiplier
`define PID_W_OS   3     // Oversample exponent

// Wishbone widths
`define PID_W_WB   32
`define PID_W_ADR  8

`endif

// File: verilog/pid_pipeline.sv
`timescale 1ns/10ps
`include "pid_macros.svh"

module pid_pipeline (
    input  logic                          clk_in,
    input  logic                          reset,
    // Configuration bus
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  logic [`PID_W_ADR-1:0]         wb_adr,
    input  logic [`PID_W_WB-1:0]          wb_wdata,
    output logic [`PID_W_WB-1:0]          wb_rdata,
    output logic                          wb_ack,
    // Raw samples
    input  logic                          src_dv,
    input  logic [`PID_W_SRC-1:0]         src_sel,
    input  logic signed [`PID_W_DIN-1:0]  src_data,
    // Oversampled tap
    output logic                          ovr_dv,
    output logic [`PID_W_CHAN-1:0]        ovr_chan,
    output logic signed [`PID_W_DIN-1:0]  ovr_data,
    // Controller output
    output logic                          out_dv,
    output logic [`PID_W_CHAN-1:0]        out_chan,
    output logic signed [`PID_W_DOUT-1:0] out_data
);
    import pid_pkg::*;

    cfg_if   cfg ();
    sample_t sample_idp;
    sample_t sample_ovr;
    delta_t  delta_pid;

    // ------------------------------
    // Input side
    // ------------------------------
    cfg_decoder cfg_decoder_inst (
        .clk_in   (clk_in),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_wdata (wb_wdata),
        .wb_rdata (wb_rdata),
        .wb_ack   (wb_ack),
        .cfg      (cfg)
    );

    instr_dispatch instr_dispatch_inst (
        .clk_in   (clk_in),
        .reset    (reset),
        .src_dv   (src_dv),
        .src_sel  (src_sel),
        .src_data (src_data),
        .cfg      (cfg),
        .sample   (sample_idp)
    );

    // ------------------------------
    // Processing
    // ------------------------------
    oversample_filter oversample_filter_inst (
        .clk_in     (clk_in),
        .reset      (reset),
        .sample_in  (sample_idp),
        .cfg        (cfg),
        .sample_out (sample_ovr)
    );

    pid_filter pid_filter_inst (
        .clk_in    (clk_in),
        .reset     (reset),
        .sample_in (sample_ovr),
        .cfg       (cfg),
        .delta     (delta_pid)
    );

    // ------------------------------
    // Output side
    // ------------------------------
    output_filter output_filter_inst (
        .clk_in   (clk_in),
        .reset    (reset),
        .delta    (delta_pid),
        .cfg      (cfg),
        .out_dv   (out_dv),
        .out_chan (out_chan),
        .out_data (out_data)
    );

    assign ovr_dv   = sample_ovr.dv;    // Tap of the averaged stream
    assign ovr_chan = sample_ovr.chan;
    assign ovr_data = sample_ovr.data;

endmodule

// File: verilog/pid_pkg.sv
`include "pid_macros.svh"

package pid_pkg;

    // Register opcode from wb_adr[7:4]
    typedef enum logic [3:0] {
        REG_SRC_MAP  = 4'h0,    // Source in chan field, data[2] enable, data[1:0] channel
        REG_OS       = 4'h1,    // Oversample exponent, clears all sums
        REG_SETPOINT = 4'h2,
        REG_KP       = 4'h3,
        REG_KI       = 4'h4,
        REG_KD       = 4'h5,
        REG_MULT     = 4'h6,
        REG_RSHIFT   = 4'h7,
        REG_MIN      = 4'h8,
        REG_MAX      = 4'h9
    } cfg_reg_e;

    // How much error history a channel holds
    typedef enum logic [1:0] {
        HIST_EMPTY,
        HIST_ONE,
        HIST_FULL
    } pid_state_e;

    // Dispatch and oversample stream
    typedef struct packed {
        logic                         dv;
        logic [`PID_W_CHAN-1:0]       chan;
        logic signed [`PID_W_DIN-1:0] data;
    } sample_t;

    // PID correction stream
    typedef struct packed {
        logic                          dv;
        logic [`PID_W_CHAN-1:0]        chan;
        logic signed [`PID_W_COMP-1:0] data;
    } delta_t;

endpackage
